// ==== hdl/periph_params.svh ====
// --------------------------------------------------------------------------
// Address map and register offsets of the peripheral region
// Offsets are word aligned and compared on HADDR[9:0], no byte lanes
// Window 3 of the 4 KB region is unmapped and answers ERROR
// --------------------------------------------------------------------------
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

`define PERIPH_BASE    32'h4000_0000  // Upper 20 bits compared
`define WIN_GPIO       2'd0           // HADDR[11:10]
`define WIN_TIMER      2'd1
`define WIN_SYSCTRL    2'd2

`define AHB_DW         32             // Data bus width
`define GPIO_W         16             // Pin count

`define GPIO_DATAOUT   10'h000
`define GPIO_OUTEN     10'h004
`define GPIO_DATAIN    10'h008
`define GPIO_INTEN     10'h00C
`define GPIO_INTSTAT   10'h010        // Write 1 to clear

`define TMR_LOAD       10'h000
`define TMR_VALUE      10'h004
`define TMR_CTRL       10'h008
`define TMR_INTCLR     10'h00C
`define TMR_CTRL_EN    0              // CTRL bit positions
`define TMR_CTRL_IE    1

`define HTRANS_IDLE    2'b00
`define HTRANS_NONSEQ  2'b10

`endif

// ==== hdl/periph_pkg.sv ====
// --------------------------------------------------------------------------
// Bus bundles shared by the peripheral region
// hwdata in ahb_req_t belongs to the data phase of the previous transfer
// --------------------------------------------------------------------------
`include "periph_params.svh"

package periph_pkg;

  // Master side, address phase plus write data
  typedef struct packed {
    logic [1:0]         htrans;   // Bit 1 set for an active transfer
    logic               hwrite;
    logic               hpriv;    // HPROT privileged bit
    logic [31:0]        haddr;
    logic [`AHB_DW-1:0] hwdata;
  } ahb_req_t;

  // Slave side response
  typedef struct packed {
    logic               hreadyout;
    logic               hresp;    // 1 means ERROR
    logic [`AHB_DW-1:0] hrdata;
  } ahb_rsp_t;

  // One-hot slave select
  typedef struct packed {
    logic dflt;
    logic gpio;
    logic timer;
    logic sysctrl;
  } slave_sel_t;

  // Privileged-only flags per slave
  typedef struct packed {
    logic gpio;
    logic timer;
    logic sysctrl;
  } perm_t;

endpackage

// ==== hdl/ahb_decoder.sv ====
// --------------------------------------------------------------------------
// Address phase decode into one-hot selects
// Refused, unmapped and out-of-region accesses go to the default slave
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "periph_params.svh"

module ahb_decoder (
  input  logic                   hsel_i,    // Region select from the bus
  input  logic [31:0]            haddr_i,
  input  logic                   hpriv_i,   // Privileged access
  input  periph_pkg::perm_t      perm_i,    // Privileged-only flags
  output periph_pkg::slave_sel_t sel_o
);

  localparam logic [31:0] BASE = `PERIPH_BASE;

  logic       in_region;  // Inside the 4 KB region
  logic [1:0] win;        // Window index
  logic       user;       // Unprivileged access

  assign in_region = (haddr_i[31:12] == BASE[31:12]);
  assign win       = haddr_i[11:10];
  assign user      = ~hpriv_i;

  // --------------------------------------------------------------------------
  // Slave hits with the privilege filter
  // --------------------------------------------------------------------------
  assign sel_o.gpio    = hsel_i & in_region & (win == `WIN_GPIO)
                         & ~(perm_i.gpio & user);
  assign sel_o.timer   = hsel_i & in_region & (win == `WIN_TIMER)
                         & ~(perm_i.timer & user);
  assign sel_o.sysctrl = hsel_i & in_region & (win == `WIN_SYSCTRL)
                         & ~(perm_i.sysctrl & user);

  // Everything else selected ends at the default slave
  assign sel_o.dflt = hsel_i & ~(sel_o.gpio | sel_o.timer | sel_o.sysctrl);

endmodule

// ==== hdl/ahb_slave_mux.sv ====
// --------------------------------------------------------------------------
// Data phase response multiplexer toward the master
// Select is registered on hready_i, one cycle behind the address phase
// Nothing registered returns ready, OKAY and zero data
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module ahb_slave_mux (
  input  logic                   ahb_clk_i,
  input  logic                   arst_n_i,
  input  logic                   hready_i,       // Looped back hreadyout
  input  periph_pkg::slave_sel_t sel_i,          // Address phase selects
  input  periph_pkg::ahb_rsp_t   dflt_rsp_i,
  input  periph_pkg::ahb_rsp_t   gpio_rsp_i,
  input  periph_pkg::ahb_rsp_t   timer_rsp_i,
  input  periph_pkg::ahb_rsp_t   sysctrl_rsp_i,  // External slave
  output periph_pkg::ahb_rsp_t   rsp_o
);

  periph_pkg::slave_sel_t sel_q;  // Data phase owner

  always_ff @(posedge ahb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q <= '0;
    end else if (hready_i) begin
      sel_q <= sel_i;                 // Advance only when the bus moves
    end
  end

  always_comb begin
    if (sel_q.dflt) begin
      rsp_o = dflt_rsp_i;
    end else if (sel_q.gpio) begin
      rsp_o = gpio_rsp_i;
    end else if (sel_q.timer) begin
      rsp_o = timer_rsp_i;
    end else if (sel_q.sysctrl) begin
      rsp_o = sysctrl_rsp_i;          // May stall the master
    end else begin
      rsp_o = '{hreadyout: 1'b1, hresp: 1'b0, hrdata: '0};
    end
  end

endmodule

// ==== hdl/ahb_default_slave.sv ====
// --------------------------------------------------------------------------
// Default slave for unmapped and refused accesses
// Active transfers get the two-cycle ERROR, idle ones OKAY without waits
// Read data is always zero
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module ahb_default_slave (
  input  logic                 ahb_clk_i,
  input  logic                 arst_n_i,
  input  logic                 sel_i,      // Default slave select
  input  logic [1:0]           htrans_i,
  input  logic                 hready_i,
  output periph_pkg::ahb_rsp_t rsp_o
);

  typedef enum logic [1:0] {
    IDLE,
    ERR_FIRST,    // hresp 1, hreadyout 0
    ERR_SECOND    // hresp 1, hreadyout 1
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   accept;   // Active transfer taken this cycle

  assign accept = sel_i & hready_i & htrans_i[1];

  always_comb begin
    case (state_q)
      IDLE:       state_d = accept ? ERR_FIRST : IDLE;
      ERR_FIRST:  state_d = ERR_SECOND;
      ERR_SECOND: state_d = accept ? ERR_FIRST : IDLE;  // Back to back errors
      default:    state_d = IDLE;
    endcase
  end

  always_ff @(posedge ahb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign rsp_o.hreadyout = (state_q != ERR_FIRST);
  assign rsp_o.hresp     = (state_q != IDLE);
  assign rsp_o.hrdata    = '0;

endmodule

// ==== hdl/ahb_gpio.sv ====
// --------------------------------------------------------------------------
// GPIO block with zero wait states on AHB
// Pins pass a two-flop synchronizer, rising edges set INTSTAT if enabled
// INTSTAT bits clear on write 1, gpio_int_o is their OR
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "periph_params.svh"

module ahb_gpio (
  input  logic                 ahb_clk_i,
  input  logic                 arst_n_i,
  input  logic                 sel_i,
  input  logic                 hready_i,
  input  periph_pkg::ahb_req_t req_i,
  input  logic [`GPIO_W-1:0]   gpio_in_i,    // Asynchronous pins
  output periph_pkg::ahb_rsp_t rsp_o,
  output logic [`GPIO_W-1:0]   gpio_out_o,
  output logic [`GPIO_W-1:0]   gpio_en_o,
  output logic                 gpio_int_o
);

  logic               wr_q;       // Write pending in data phase
  logic [9:0]         addr_q;     // Data phase register offset
  logic               wr_en;
  logic [`GPIO_W-1:0] wdata;
  logic [`GPIO_W-1:0] sync1_q;
  logic [`GPIO_W-1:0] sync2_q;
  logic [`GPIO_W-1:0] prev_q;     // For edge detection
  logic [`GPIO_W-1:0] inten_q;
  logic [`GPIO_W-1:0] intstat_q;
  logic [`GPIO_W-1:0] clr;        // Write 1 to clear mask

  // --------------------------------------------------------------------------
  // Address phase capture
  // --------------------------------------------------------------------------
  always_ff @(posedge ahb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_q <= 1'b0;
    end else if (hready_i) begin
      wr_q <= sel_i & req_i.htrans[1] & req_i.hwrite;
    end
  end

  always_ff @(posedge ahb_clk_i) begin
    if (hready_i && sel_i && req_i.htrans[1]) begin
      addr_q <= req_i.haddr[9:0];
    end
  end

  assign wr_en = wr_q & hready_i;                 // Ends with the data phase
  assign wdata = req_i.hwdata[`GPIO_W-1:0];
  assign clr   = (wr_en && addr_q == `GPIO_INTSTAT) ? wdata : '0;

  // --------------------------------------------------------------------------
  // Registers, synchronizer and interrupt status
  // --------------------------------------------------------------------------
  always_ff @(posedge ahb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_out_o <= '0;
      gpio_en_o  <= '0;
      inten_q    <= '0;
      sync1_q    <= '0;
      sync2_q    <= '0;
      prev_q     <= '0;
      intstat_q  <= '0;
    end else begin
      if (wr_en && addr_q == `GPIO_DATAOUT) gpio_out_o <= wdata;
      if (wr_en && addr_q == `GPIO_OUTEN)   gpio_en_o  <= wdata;
      if (wr_en && addr_q == `GPIO_INTEN)   inten_q    <= wdata;
      sync1_q   <= gpio_in_i;
      sync2_q   <= sync1_q;
      prev_q    <= sync2_q;
      intstat_q <= (intstat_q & ~clr) | (sync2_q & ~prev_q & inten_q);  // New edge wins
    end
  end

  assign gpio_int_o = |intstat_q;

  always_comb begin
    rsp_o = '{hreadyout: 1'b1, hresp: 1'b0, hrdata: '0};
    case (addr_q)
      `GPIO_DATAOUT: rsp_o.hrdata[`GPIO_W-1:0] = gpio_out_o;
      `GPIO_OUTEN:   rsp_o.hrdata[`GPIO_W-1:0] = gpio_en_o;
      `GPIO_DATAIN:  rsp_o.hrdata[`GPIO_W-1:0] = sync2_q;   // Synchronized pins
      `GPIO_INTEN:   rsp_o.hrdata[`GPIO_W-1:0] = inten_q;
      `GPIO_INTSTAT: rsp_o.hrdata[`GPIO_W-1:0] = intstat_q;
      default:       rsp_o.hrdata = '0;
    endcase
  end

endmodule

// ==== hdl/timer_counter.sv ====
// --------------------------------------------------------------------------
// Periodic down counter, one step per enabled tick
// At value 1 a tick reloads and sets the status, a load write wins
// Counting from 0 wraps to all ones
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module timer_counter (
  input  logic        ahb_clk_i,
  input  logic        arst_n_i,
  input  logic        tick_i,       // Clock enable from outside
  input  logic        enable_i,
  input  logic        load_wr_i,    // Copy load value now
  input  logic [31:0] load_val_i,
  input  logic        int_clr_i,
  output logic [31:0] value_o,
  output logic        int_stat_o
);

  logic step;     // Counting this cycle
  logic expire;   // Reaching the end of a period

  assign step   = tick_i & enable_i;
  assign expire = step & (value_o == 32'd1);

  always_ff @(posedge ahb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      value_o    <= '0;
      int_stat_o <= 1'b0;
    end else begin
      if (load_wr_i || expire) begin
        value_o <= load_val_i;
      end else if (step) begin
        value_o <= value_o - 32'd1;
      end
      int_stat_o <= (int_stat_o & ~int_clr_i) | expire;  // Expiry beats clear
    end
  end

endmodule

// ==== hdl/ahb_timer.sv ====
// --------------------------------------------------------------------------
// AHB front end of the single timer, zero wait states
// LOAD and CTRL live here, VALUE and status in the counter
// timer_int_o is the status masked by CTRL interrupt enable
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "periph_params.svh"

module ahb_timer (
  input  logic                 ahb_clk_i,
  input  logic                 arst_n_i,
  input  logic                 sel_i,
  input  logic                 hready_i,
  input  periph_pkg::ahb_req_t req_i,
  input  logic                 timer_clken_i,  // Count tick
  output periph_pkg::ahb_rsp_t rsp_o,
  output logic                 timer_int_o
);

  logic        wr_q;       // Write pending in data phase
  logic [9:0]  addr_q;
  logic        wr_en;
  logic [31:0] load_q;
  logic [1:0]  ctrl_q;     // Bit 0 enable, bit 1 interrupt enable
  logic        load_wr;
  logic        int_clr;
  logic [31:0] load_val;
  logic [31:0] value;
  logic        int_stat;

  always_ff @(posedge ahb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_q <= 1'b0;
    end else if (hready_i) begin
      wr_q <= sel_i & req_i.htrans[1] & req_i.hwrite;
    end
  end

  always_ff @(posedge ahb_clk_i) begin
    if (hready_i && sel_i && req_i.htrans[1]) begin
      addr_q <= req_i.haddr[9:0];
    end
  end

  assign wr_en    = wr_q & hready_i;
  assign load_wr  = wr_en & (addr_q == `TMR_LOAD);
  assign int_clr  = wr_en & (addr_q == `TMR_INTCLR);
  assign load_val = load_wr ? req_i.hwdata : load_q;  // New value on the write edge

  always_ff @(posedge ahb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      load_q <= '0;
      ctrl_q <= '0;
    end else begin
      if (load_wr) load_q <= req_i.hwdata;
      if (wr_en && addr_q == `TMR_CTRL) ctrl_q <= req_i.hwdata[1:0];
    end
  end

  timer_counter u_timer_counter (
    .ahb_clk_i  (ahb_clk_i),
    .arst_n_i   (arst_n_i),
    .tick_i     (timer_clken_i),
    .enable_i   (ctrl_q[`TMR_CTRL_EN]),
    .load_wr_i  (load_wr),
    .load_val_i (load_val),
    .int_clr_i  (int_clr),
    .value_o    (value),
    .int_stat_o (int_stat)
  );

  assign timer_int_o = int_stat & ctrl_q[`TMR_CTRL_IE];

  always_comb begin
    rsp_o = '{hreadyout: 1'b1, hresp: 1'b0, hrdata: '0};
    case (addr_q)
      `TMR_LOAD:  rsp_o.hrdata = load_q;
      `TMR_VALUE: rsp_o.hrdata = value;
      `TMR_CTRL:  rsp_o.hrdata = {30'd0, ctrl_q};
      default:    rsp_o.hrdata = '0;   // INTCLR reads zero
    endcase
  end

endmodule

// ==== hdl/beetle_periph_top.sv ====
// --------------------------------------------------------------------------
// AHB peripheral region, single clock ahb_clk_i
// hready_i must be the looped back rsp_o.hreadyout
// System control slave is external, only its select leaves here
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "periph_params.svh"

module beetle_periph_top (
  input  logic                 ahb_clk_i,
  input  logic                 arst_n_i,
  input  logic                 hsel_i,
  input  logic                 hready_i,
  input  periph_pkg::ahb_req_t req_i,
  input  periph_pkg::perm_t    perm_i,         // Privileged-only flags
  input  periph_pkg::ahb_rsp_t sysctrl_rsp_i,
  input  logic [`GPIO_W-1:0]   gpio_in_i,
  input  logic                 timer_clken_i,
  output periph_pkg::ahb_rsp_t rsp_o,
  output logic                 sysctrl_sel_o,
  output logic [`GPIO_W-1:0]   gpio_out_o,
  output logic [`GPIO_W-1:0]   gpio_en_o,
  output logic                 gpio_int_o,
  output logic                 timer_int_o
);

  periph_pkg::slave_sel_t sel;        // Address phase selects
  periph_pkg::ahb_rsp_t   dflt_rsp;
  periph_pkg::ahb_rsp_t   gpio_rsp;
  periph_pkg::ahb_rsp_t   timer_rsp;

  assign sysctrl_sel_o = sel.sysctrl;

  // --------------------------------------------------------------------------
  // Decode, mux and default slave
  // --------------------------------------------------------------------------
  ahb_decoder u_ahb_decoder (
    .hsel_i  (hsel_i),
    .haddr_i (req_i.haddr),
    .hpriv_i (req_i.hpriv),
    .perm_i  (perm_i),
    .sel_o   (sel)
  );

  ahb_slave_mux u_ahb_slave_mux (
    .ahb_clk_i     (ahb_clk_i),
    .arst_n_i      (arst_n_i),
    .hready_i      (hready_i),
    .sel_i         (sel),
    .dflt_rsp_i    (dflt_rsp),
    .gpio_rsp_i    (gpio_rsp),
    .timer_rsp_i   (timer_rsp),
    .sysctrl_rsp_i (sysctrl_rsp_i),
    .rsp_o         (rsp_o)
  );

  ahb_default_slave u_ahb_default_slave (
    .ahb_clk_i (ahb_clk_i),
    .arst_n_i  (arst_n_i),
    .sel_i     (sel.dflt),
    .htrans_i  (req_i.htrans),
    .hready_i  (hready_i),
    .rsp_o     (dflt_rsp)
  );

  // --------------------------------------------------------------------------
  // Peripherals
  // --------------------------------------------------------------------------
  ahb_gpio u_ahb_gpio (
    .ahb_clk_i  (ahb_clk_i),
    .arst_n_i   (arst_n_i),
    .sel_i      (sel.gpio),
    .hready_i   (hready_i),
    .req_i      (req_i),
    .gpio_in_i  (gpio_in_i),
    .rsp_o      (gpio_rsp),
    .gpio_out_o (gpio_out_o),
    .gpio_en_o  (gpio_en_o),
    .gpio_int_o (gpio_int_o)
  );

  ahb_timer u_ahb_timer (
    .ahb_clk_i     (ahb_clk_i),
    .arst_n_i      (arst_n_i),
    .sel_i         (sel.timer),
    .hready_i      (hready_i),
    .req_i         (req_i),
    .timer_clken_i (timer_clken_i),
    .rsp_o         (timer_rsp),
    .timer_int_o   (timer_int_o)
  );

endmodule

// ==== bench/periph_assert.sv ====
// --------------------------------------------------------------------------
// Bus response rules of the peripheral region, bound to the top level
// INTEN comes from the GPIO block through the bind connection
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "periph_params.svh"

module periph_assert (
  input logic                 ahb_clk_i,
  input logic                 arst_n_i,
  input periph_pkg::ahb_rsp_t rsp_i,       // Response toward the master
  input logic [`GPIO_W-1:0]   inten_i,
  input logic                 gpio_int_i
);

  // First ERROR cycle stalls the master
  a_err_first: assert property (@(posedge ahb_clk_i) disable iff (!arst_n_i)
    $rose(rsp_i.hresp) |-> !rsp_i.hreadyout)
    else $error("ERROR response did not start with hreadyout low");

  // Second ERROR cycle completes with hresp held
  a_err_second: assert property (@(posedge ahb_clk_i) disable iff (!arst_n_i)
    $rose(rsp_i.hresp) |=> (rsp_i.hreadyout && rsp_i.hresp))
    else $error("ERROR response second cycle wrong");

  a_reset_ready: assert property (@(posedge ahb_clk_i)
    !arst_n_i |-> rsp_i.hreadyout)
    else $error("hreadyout low during reset");

  a_gpio_int_masked: assert property (@(posedge ahb_clk_i) disable iff (!arst_n_i)
    (inten_i == '0) |-> !gpio_int_i)
    else $error("gpio_int_o set with all INTEN bits clear");

endmodule

bind beetle_periph_top periph_assert u_periph_assert (
  .ahb_clk_i  (ahb_clk_i),
  .arst_n_i   (arst_n_i),
  .rsp_i      (rsp_o),
  .inten_i    (u_ahb_gpio.inten_q),
  .gpio_int_i (gpio_int_o)
);

// ==== bench/periph_tb.sv ====
// --------------------------------------------------------------------------
// Directed testbench for the AHB peripheral region
// One transfer in flight at a time, hready_i is looped from rsp_o
// Inputs change on the falling edge, responses are read 1 ns later
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "periph_params.svh"

module periph_tb;

  localparam int TIMEOUT_CYCLES = 2000;

  logic                 ahb_clk = 1'b0;
  logic                 arst_n;
  logic                 hsel;
  logic                 hready;
  periph_pkg::ahb_req_t req;
  periph_pkg::perm_t    perm;
  periph_pkg::ahb_rsp_t sysctrl_rsp;
  logic [`GPIO_W-1:0]   gpio_in;
  logic                 timer_clken;
  periph_pkg::ahb_rsp_t rsp;
  logic                 sysctrl_sel;
  logic [`GPIO_W-1:0]   gpio_out;
  logic [`GPIO_W-1:0]   gpio_en;
  logic                 gpio_int;
  logic                 timer_int;

  int seed   = 78869;
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  assign hready = rsp.hreadyout;     // Single master loopback

  beetle_periph_top dut_i (
    .ahb_clk_i     (ahb_clk),
    .arst_n_i      (arst_n),
    .hsel_i        (hsel),
    .hready_i      (hready),
    .req_i         (req),
    .perm_i        (perm),
    .sysctrl_rsp_i (sysctrl_rsp),
    .gpio_in_i     (gpio_in),
    .timer_clken_i (timer_clken),
    .rsp_o         (rsp),
    .sysctrl_sel_o (sysctrl_sel),
    .gpio_out_o    (gpio_out),
    .gpio_en_o     (gpio_en),
    .gpio_int_o    (gpio_int),
    .timer_int_o   (timer_int)
  );

  always #4 ahb_clk = ~ahb_clk;      // 8 ns period

  always @(posedge ahb_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a transfer never completed", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Helpers and compare tasks
  // --------------------------------------------------------------------------
  function automatic logic [31:0] reg_addr(input logic [1:0] win, input logic [9:0] off);
    reg_addr = `PERIPH_BASE | {20'd0, win, off};
  endfunction

  function automatic periph_pkg::ahb_rsp_t okay_rsp(input logic [31:0] data);
    okay_rsp = '{hreadyout: 1'b1, hresp: 1'b0, hrdata: data};
  endfunction

  task automatic check_rsp(input string name, input periph_pkg::ahb_rsp_t got,
                           input periph_pkg::ahb_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got ready=%h resp=%h data=0x%h, expected ready=%h resp=%h data=0x%h",
               name, got.hreadyout, got.hresp, got.hrdata,
               exp.hreadyout, exp.hresp, exp.hrdata);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // --------------------------------------------------------------------------
  // Bus tasks
  // --------------------------------------------------------------------------
  task automatic drive_addr(input logic write, input logic [31:0] addr, input logic priv);
    hsel       = 1'b1;
    req.htrans = `HTRANS_NONSEQ;
    req.hwrite = write;
    req.hpriv  = priv;
    req.haddr  = addr;
  endtask

  task automatic drive_idle(input logic [31:0] wdata);
    hsel       = 1'b0;               // Mux falls back to ready OKAY
    req.htrans = `HTRANS_IDLE;
    req.hwrite = 1'b0;
    req.hwdata = wdata;              // Data phase of the last transfer
  endtask

  task automatic do_transfer(input logic write, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic priv,
                             output periph_pkg::ahb_rsp_t got);
    @(negedge ahb_clk);
    drive_addr(write, addr, priv);
    @(negedge ahb_clk);
    drive_idle(wdata);
    #1;
    while (!rsp.hreadyout) begin     // Wait states
      @(negedge ahb_clk);
      #1;
    end
    got = rsp;                       // Last data phase cycle
  endtask

  task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data, input logic priv);
    periph_pkg::ahb_rsp_t got;
    do_transfer(1'b1, addr, data, priv, got);
    check_flag("rsp_o.hresp on write", got.hresp, 1'b0);
  endtask

  task automatic ahb_read(input logic [31:0] addr, input logic priv,
                          output periph_pkg::ahb_rsp_t got);
    do_transfer(1'b0, addr, 32'd0, priv, got);
  endtask

  task automatic read_expect(input string name, input logic [31:0] addr, input logic [31:0] exp);
    periph_pkg::ahb_rsp_t got;
    ahb_read(addr, 1'b1, got);
    check_rsp(name, got, okay_rsp(exp));
  endtask

  // Two-cycle ERROR fixed by the default slave timing
  task automatic ahb_expect_error(input logic write, input logic [31:0] addr,
                                  input logic [31:0] wdata, input logic priv);
    periph_pkg::ahb_rsp_t err1;
    periph_pkg::ahb_rsp_t err2;
    err1 = '{hreadyout: 1'b0, hresp: 1'b1, hrdata: 32'd0};
    err2 = '{hreadyout: 1'b1, hresp: 1'b1, hrdata: 32'd0};
    @(negedge ahb_clk);
    drive_addr(write, addr, priv);
    @(negedge ahb_clk);
    drive_idle(wdata);
    #1 check_rsp("rsp_o ERROR cycle 1", rsp, err1);
    @(negedge ahb_clk);
    #1 check_rsp("rsp_o ERROR cycle 2", rsp, err2);
  endtask

  task automatic tick_timer(input logic [31:0] n);
    @(negedge ahb_clk);
    timer_clken = 1'b1;
    repeat (n) @(negedge ahb_clk);   // n enabled rising edges
    timer_clken = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_gpio_output;
    logic [31:0] dout;
    logic [31:0] oen;
    dout = $random(seed);
    oen  = $random(seed);
    ahb_write(reg_addr(`WIN_GPIO, `GPIO_DATAOUT), dout, 1'b1);  // Upper bits ignored
    ahb_write(reg_addr(`WIN_GPIO, `GPIO_OUTEN), oen, 1'b1);
    read_expect("GPIO DATAOUT", reg_addr(`WIN_GPIO, `GPIO_DATAOUT), {16'd0, dout[15:0]});
    read_expect("GPIO OUTEN", reg_addr(`WIN_GPIO, `GPIO_OUTEN), {16'd0, oen[15:0]});
    check_word("gpio_out_o", {16'd0, gpio_out}, {16'd0, dout[15:0]});
    check_word("gpio_en_o", {16'd0, gpio_en}, {16'd0, oen[15:0]});
  endtask

  task automatic test_gpio_irq;
    logic [31:0] r;
    logic [15:0] inten;
    logic [15:0] pins;
    logic [15:0] stat;
    r     = $random(seed);
    inten = r[15:0] | 16'h0001;      // At least pin 0 fires
    r     = $random(seed);
    pins  = r[15:0] | 16'h0001;
    stat  = inten & pins;
    @(negedge ahb_clk);
    gpio_in = pins;                  // INTEN still clear
    repeat (4) @(negedge ahb_clk);
    #1 check_flag("gpio_int_o with INTEN clear", gpio_int, 1'b0);
    @(negedge ahb_clk);
    gpio_in = '0;
    repeat (3) @(negedge ahb_clk);   // Synchronizer back to zero
    ahb_write(reg_addr(`WIN_GPIO, `GPIO_INTEN), {16'd0, inten}, 1'b1);
    @(negedge ahb_clk);
    gpio_in = pins;
    repeat (2) @(negedge ahb_clk);
    #1 check_flag("gpio_int_o before sync", gpio_int, 1'b0);
    @(negedge ahb_clk);
    #1 check_flag("gpio_int_o", gpio_int, 1'b1);           // Third clock
    read_expect("GPIO INTSTAT", reg_addr(`WIN_GPIO, `GPIO_INTSTAT), {16'd0, stat});
    read_expect("GPIO DATAIN", reg_addr(`WIN_GPIO, `GPIO_DATAIN), {16'd0, pins});
    ahb_write(reg_addr(`WIN_GPIO, `GPIO_INTSTAT), {16'd0, stat}, 1'b1);
    read_expect("GPIO INTSTAT after clear", reg_addr(`WIN_GPIO, `GPIO_INTSTAT), 32'd0);
    check_flag("gpio_int_o after clear", gpio_int, 1'b0);
    @(negedge ahb_clk);
    gpio_in = '0;                    // Falling pins set nothing
  endtask

  task automatic test_timer;
    logic [31:0] r;
    logic [31:0] n;
    logic [31:0] k;
    r = $random(seed);
    n = 32'd4 + {28'd0, r[3:0]};
    r = $random(seed);
    k = 32'd1 + (r[7:0] % (n - 32'd1));                    // 1 to n-1
    ahb_write(reg_addr(`WIN_TIMER, `TMR_LOAD), n, 1'b1);
    ahb_write(reg_addr(`WIN_TIMER, `TMR_CTRL), 32'd3, 1'b1);  // Enable, int enable
    read_expect("TIMER VALUE after load", reg_addr(`WIN_TIMER, `TMR_VALUE), n);
    tick_timer(k);
    read_expect("TIMER VALUE mid period", reg_addr(`WIN_TIMER, `TMR_VALUE), n - k);
    check_flag("timer_int_o mid period", timer_int, 1'b0);
    tick_timer(n - k);
    read_expect("TIMER VALUE after reload", reg_addr(`WIN_TIMER, `TMR_VALUE), n);
    check_flag("timer_int_o at expiry", timer_int, 1'b1);
    ahb_write(reg_addr(`WIN_TIMER, `TMR_INTCLR), 32'd1, 1'b1);
    read_expect("TIMER VALUE no tick", reg_addr(`WIN_TIMER, `TMR_VALUE), n);
    check_flag("timer_int_o after clear", timer_int, 1'b0);
    repeat (10) @(negedge ahb_clk);  // clken held low
    read_expect("TIMER VALUE held", reg_addr(`WIN_TIMER, `TMR_VALUE), n);
  endtask

  task automatic test_privilege;
    logic [31:0] load;
    load = $random(seed);
    ahb_write(reg_addr(`WIN_TIMER, `TMR_LOAD), load, 1'b1);
    @(negedge ahb_clk);
    perm.timer = 1'b1;
    ahb_expect_error(1'b0, reg_addr(`WIN_TIMER, `TMR_LOAD), 32'd0, 1'b0);
    ahb_expect_error(1'b1, reg_addr(`WIN_TIMER, `TMR_LOAD), ~load, 1'b0);
    read_expect("TIMER LOAD privileged", reg_addr(`WIN_TIMER, `TMR_LOAD), load);
    @(negedge ahb_clk);
    perm.timer = 1'b0;
  endtask

  task automatic sysctrl_pass(input logic [31:0] addr, input logic [31:0] wait_n,
                              input logic [31:0] data);
    periph_pkg::ahb_rsp_t exp;
    exp = okay_rsp(data);
    @(negedge ahb_clk);
    drive_addr(1'b0, addr, 1'b1);
    sysctrl_rsp.hreadyout = 1'b0;    // Not owned yet, mux stays ready
    #1 check_flag("sysctrl_sel_o", sysctrl_sel, 1'b1);
    @(negedge ahb_clk);
    drive_idle(32'd0);
    repeat (wait_n) begin
      #1 check_flag("rsp_o.hreadyout during stall", rsp.hreadyout, 1'b0);
      @(negedge ahb_clk);
    end
    sysctrl_rsp = exp;
    #1 check_rsp("rsp_o from sysctrl", rsp, exp);
    check_flag("sysctrl_sel_o after address phase", sysctrl_sel, 1'b0);
    @(negedge ahb_clk);
    sysctrl_rsp = okay_rsp(32'd0);
  endtask

  task automatic test_unmapped_sysctrl;
    logic [31:0] r;
    logic [31:0] data;
    ahb_expect_error(1'b0, reg_addr(2'd3, 10'h000), 32'd0, 1'b1);  // Window 3
    r    = $random(seed);
    data = $random(seed);
    sysctrl_pass(reg_addr(`WIN_SYSCTRL, 10'h010), 32'd1 + {29'd0, r[2:0]}, data);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    arst_n      = 1'b0;
    hsel        = 1'b0;
    req         = '0;
    perm        = '0;
    sysctrl_rsp = okay_rsp(32'd0);
    gpio_in     = '0;
    timer_clken = 1'b0;
    repeat (3) @(posedge ahb_clk);
    @(negedge ahb_clk);
    arst_n = 1'b1;
    test_gpio_output();
    test_gpio_irq();
    test_timer();
    test_privilege();
    test_unmapped_sysctrl();
    @(negedge ahb_clk);
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/periph_pkg.sv
hdl/ahb_decoder.sv
hdl/ahb_slave_mux.sv
hdl/ahb_default_slave.sv
hdl/ahb_gpio.sv
hdl/timer_counter.sv
hdl/ahb_timer.sv
hdl/beetle_periph_top.sv
bench/periph_assert.sv
bench/periph_tb.sv

// ==== Makefile ====
# Verilator build and run of the peripheral region testbench

SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP      := periph_tb
FILELIST := compile.f
OBJ_DIR  := obj_dir
PASS_MSG := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

# Status comes from the search for the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
